// ==== verilog/rv_isa_pkg.sv ====
// RV32I encoding definitions shared by the decode and execute stages.
// Covers the opcodes, funct3/funct7 values, the instruction field layout
// and the internal ALU and branch operation codes.

package rv_isa_pkg;

    // major opcodes
    localparam logic [6:0] OP_IMM    = 7'b0010011;
    localparam logic [6:0] OP_REG    = 7'b0110011;
    localparam logic [6:0] OP_LUI    = 7'b0110111;
    localparam logic [6:0] OP_AUIPC  = 7'b0010111;
    localparam logic [6:0] OP_JAL    = 7'b1101111;
    localparam logic [6:0] OP_BRANCH = 7'b1100011;

    // alu funct3
    localparam logic [2:0] F3_ADD_SUB = 3'b000;
    localparam logic [2:0] F3_SLL     = 3'b001;
    localparam logic [2:0] F3_SLT     = 3'b010;
    localparam logic [2:0] F3_XOR     = 3'b100;
    localparam logic [2:0] F3_SRL_SRA = 3'b101;
    localparam logic [2:0] F3_OR      = 3'b110;
    localparam logic [2:0] F3_AND     = 3'b111;

    // branch funct3
    localparam logic [2:0] F3_BEQ = 3'b000;
    localparam logic [2:0] F3_BNE = 3'b001;
    localparam logic [2:0] F3_BLT = 3'b100;
    localparam logic [2:0] F3_BGE = 3'b101;

    // selects SUB and SRA
    localparam logic [6:0] FUNCT7_ALT = 7'b0100000;

    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } instr_t;

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_XOR,
        ALU_OR, ALU_AND, ALU_SRL, ALU_SRA, ALU_PASS_B
    } alu_op_t;

    typedef enum logic [2:0] {
        BR_NONE, BR_EQ, BR_NE, BR_LT, BR_GE, BR_JUMP
    } br_op_t;

endpackage

// ==== verilog/pipe_pkg.sv ====
// Pipeline packet layouts and core-wide constants.
// Each stage register carries one of these structs; the retire record
// is the architectural trace the core exposes per completed instruction.

package pipe_pkg;

    localparam int XLEN = 32;

    // fetch starts here out of reset
    localparam logic [XLEN-1:0] RESET_PC = 32'h0000_0000;

    // addi x0, x0, 0
    localparam logic [31:0] NOP_INSTR = 32'h0000_0013;

    typedef struct packed {
        logic [XLEN-1:0] pc;
        logic [31:0]     instr;
    } fetch_pkt_t;

    typedef struct packed {
        logic [XLEN-1:0]     pc;
        logic [4:0]          rs1;
        logic [4:0]          rs2;
        logic [XLEN-1:0]     rs1_val;
        logic [XLEN-1:0]     rs2_val;
        logic [XLEN-1:0]     imm;
        logic [4:0]          rd;
        logic                we;
        logic                use_imm;
        logic                use_pc;
        rv_isa_pkg::alu_op_t alu_op;
        rv_isa_pkg::br_op_t  br_op;
    } dec_pkt_t;

    typedef struct packed {
        logic [XLEN-1:0] pc;
        logic [4:0]      rd;
        logic            we;
        logic [XLEN-1:0] result;
    } wb_pkt_t;

    typedef struct packed {
        logic            valid;
        logic [XLEN-1:0] pc;
        logic            we;
        logic [4:0]      rd;
        logic [XLEN-1:0] data;
    } retire_t;

endpackage

// ==== verilog/pipe_reg.sv ====
// Stage register holding one payload plus a valid bit.
// Used between every pair of stages; flush or an invalid input drops
// the valid bit and keeps the old payload.

module pipe_reg #(
    parameter type payload_t = logic
) (
    input  logic     clk,
    input  logic     i_arst_n,
    input  logic     i_flush,
    input  logic     i_valid,
    input  payload_t i_data,
    output logic     o_valid,
    output payload_t o_data
);

    logic load;

    assign load = i_valid && !i_flush;

    always_ff @(posedge clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            o_valid <= 1'b0;
        end else begin
            o_valid <= load;
        end
    end

    // payload only moves with a live item
    always_ff @(posedge clk) begin
        if (load) begin
            o_data <= i_data;
        end
    end

endmodule

// ==== verilog/fetch_unit.sv ====
// Instruction fetch with the program counter and a four-phase req/ack
// port. One request is in flight at a time; a redirect during an
// outstanding request lets the handshake finish and drops its data.

module fetch_unit (
    input  logic                 clk,
    input  logic                 i_arst_n,
    input  logic                 i_redirect,
    input  logic [31:0]          i_redirect_pc,
    input  logic                 i_imem_ack,
    input  logic [31:0]          i_imem_data,
    output logic                 o_imem_req,
    output logic [31:0]          o_imem_addr,
    output logic                 o_valid,
    output pipe_pkg::fetch_pkt_t o_pkt
);

    typedef enum logic [1:0] {
        S_IDLE,
        S_WAIT_ACK,
        S_WAIT_REL
    } state_t;

    state_t      state;
    logic [31:0] pc;
    logic [31:0] req_addr;
    logic        discard;
    logic        done;
    logic        launch;
    logic [31:0] next_pc;

    assign done   = (state == S_WAIT_ACK) && i_imem_ack;
    assign launch = (state == S_IDLE) || ((state == S_WAIT_REL) && !i_imem_ack);

    // redirect wins over sequential advance
    assign next_pc = i_redirect       ? i_redirect_pc :
                     (done && !discard) ? pc + 32'd4  : pc;

    always_ff @(posedge clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            state    <= S_IDLE;
            pc       <= pipe_pkg::RESET_PC;
            req_addr <= pipe_pkg::RESET_PC;
            discard  <= 1'b0;
        end else begin
            pc <= next_pc;
            if (launch) begin
                state    <= S_WAIT_ACK;
                req_addr <= next_pc;
            end else if (done) begin
                state   <= S_WAIT_REL;
                discard <= 1'b0;
            end else if ((state == S_WAIT_ACK) && i_redirect) begin
                // wrong-path word still on its way
                discard <= 1'b1;
            end
        end
    end

    assign o_imem_req  = (state == S_WAIT_ACK);
    assign o_imem_addr = req_addr;

    assign o_valid     = done && !discard;
    assign o_pkt.pc    = req_addr;
    // keep bus data out of the pipe when nothing was fetched
    assign o_pkt.instr = o_valid ? i_imem_data : pipe_pkg::NOP_INSTR;

endmodule

// ==== verilog/regfile.sv ====
// 32 x 32 integer register file, x0 reads as zero.
// Two read ports with write-through so decode sees the writeback value.

module regfile (
    input  logic        clk,
    input  logic        i_arst_n,
    input  logic [4:0]  i_rs1,
    input  logic [4:0]  i_rs2,
    input  logic        i_we,
    input  logic [4:0]  i_rd,
    input  logic [31:0] i_wdata,
    output logic [31:0] o_rs1_val,
    output logic [31:0] o_rs2_val
);

    logic [31:0] regs [1:31];

    always_ff @(posedge clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (i_we && (i_rd != 5'd0)) begin
            regs[i_rd] <= i_wdata;
        end
    end

    assign o_rs1_val = (i_rs1 == 5'd0)              ? 32'd0   :
                       (i_we && (i_rd == i_rs1))     ? i_wdata : regs[i_rs1];
    assign o_rs2_val = (i_rs2 == 5'd0)              ? 32'd0   :
                       (i_we && (i_rd == i_rs2))     ? i_wdata : regs[i_rs2];

endmodule

// ==== verilog/decode_unit.sv ====
// Decode stage logic between IF/ID and ID/EX.
// Splits the instruction word, builds the immediate, sets the ALU and
// branch controls and passes along the register file read data.

module decode_unit (
    input  pipe_pkg::fetch_pkt_t i_pkt,
    input  logic [31:0]          i_rs1_val,
    input  logic [31:0]          i_rs2_val,
    output logic [4:0]           o_rs1,
    output logic [4:0]           o_rs2,
    output pipe_pkg::dec_pkt_t   o_pkt
);

    rv_isa_pkg::instr_t ins;
    logic [31:0]        imm_i;
    logic [31:0]        imm_u;
    logic [31:0]        imm_b;
    logic [31:0]        imm_j;
    logic               alt;

    assign ins = rv_isa_pkg::instr_t'(i_pkt.instr);
    assign alt = (ins.funct7 == rv_isa_pkg::FUNCT7_ALT);

    assign imm_i = {{20{ins.funct7[6]}}, ins.funct7, ins.rs2};
    assign imm_u = {ins.funct7, ins.rs2, ins.rs1, ins.funct3, 12'd0};
    assign imm_b = {{20{ins.funct7[6]}}, ins.rd[0], ins.funct7[5:0], ins.rd[4:1], 1'b0};
    assign imm_j = {{12{ins.funct7[6]}}, ins.rs1, ins.funct3, ins.rs2[0],
                    ins.funct7[5:0], ins.rs2[4:1], 1'b0};

    assign o_rs1 = ins.rs1;
    assign o_rs2 = ins.rs2;

    always_comb begin
        o_pkt         = '0;
        o_pkt.pc      = i_pkt.pc;
        o_pkt.rs1     = ins.rs1;
        o_pkt.rs2     = ins.rs2;
        o_pkt.rs1_val = i_rs1_val;
        o_pkt.rs2_val = i_rs2_val;
        o_pkt.rd      = ins.rd;
        o_pkt.alu_op  = rv_isa_pkg::ALU_ADD;
        o_pkt.br_op   = rv_isa_pkg::BR_NONE;

        case (ins.opcode)
            rv_isa_pkg::OP_IMM, rv_isa_pkg::OP_REG: begin
                o_pkt.we      = 1'b1;
                o_pkt.use_imm = (ins.opcode == rv_isa_pkg::OP_IMM);
                o_pkt.imm     = imm_i;
                case (ins.funct3)
                    rv_isa_pkg::F3_ADD_SUB: begin
                        // funct7 only means SUB on the register form
                        if (alt && !o_pkt.use_imm) begin
                            o_pkt.alu_op = rv_isa_pkg::ALU_SUB;
                        end
                    end
                    rv_isa_pkg::F3_SLL: o_pkt.alu_op = rv_isa_pkg::ALU_SLL;
                    rv_isa_pkg::F3_SLT: o_pkt.alu_op = rv_isa_pkg::ALU_SLT;
                    rv_isa_pkg::F3_XOR: o_pkt.alu_op = rv_isa_pkg::ALU_XOR;
                    rv_isa_pkg::F3_SRL_SRA: begin
                        o_pkt.alu_op = alt ? rv_isa_pkg::ALU_SRA : rv_isa_pkg::ALU_SRL;
                    end
                    rv_isa_pkg::F3_OR:  o_pkt.alu_op = rv_isa_pkg::ALU_OR;
                    rv_isa_pkg::F3_AND: o_pkt.alu_op = rv_isa_pkg::ALU_AND;
                    default:            o_pkt.we     = 1'b0;
                endcase
            end
            rv_isa_pkg::OP_LUI: begin
                o_pkt.we      = 1'b1;
                o_pkt.use_imm = 1'b1;
                o_pkt.imm     = imm_u;
                o_pkt.alu_op  = rv_isa_pkg::ALU_PASS_B;
            end
            rv_isa_pkg::OP_AUIPC: begin
                o_pkt.we      = 1'b1;
                o_pkt.use_imm = 1'b1;
                o_pkt.use_pc  = 1'b1;
                o_pkt.imm     = imm_u;
            end
            rv_isa_pkg::OP_JAL: begin
                o_pkt.we    = 1'b1;
                o_pkt.imm   = imm_j;
                o_pkt.br_op = rv_isa_pkg::BR_JUMP;
            end
            rv_isa_pkg::OP_BRANCH: begin
                o_pkt.imm = imm_b;
                case (ins.funct3)
                    rv_isa_pkg::F3_BEQ: o_pkt.br_op = rv_isa_pkg::BR_EQ;
                    rv_isa_pkg::F3_BNE: o_pkt.br_op = rv_isa_pkg::BR_NE;
                    rv_isa_pkg::F3_BLT: o_pkt.br_op = rv_isa_pkg::BR_LT;
                    rv_isa_pkg::F3_BGE: o_pkt.br_op = rv_isa_pkg::BR_GE;
                    default:            o_pkt.br_op = rv_isa_pkg::BR_NONE;
                endcase
            end
            default: o_pkt.we = 1'b0;
        endcase

        // x0 never written
        if (ins.rd == 5'd0) begin
            o_pkt.we = 1'b0;
        end
    end

endmodule

// ==== verilog/execute_unit.sv ====
// Execute stage logic between ID/EX and EX/WB.
// Forwards the writeback result into the operands, runs the ALU and
// resolves branches and JAL; a taken one redirects fetch and flushes
// the two younger stages.

module execute_unit (
    input  pipe_pkg::dec_pkt_t i_pkt,
    input  logic               i_wb_valid,
    input  pipe_pkg::wb_pkt_t  i_wb_pkt,
    output pipe_pkg::wb_pkt_t  o_pkt,
    output logic               o_redirect,
    output logic [31:0]        o_redirect_pc
);

    logic        wb_live;
    logic [31:0] rs1_fwd;
    logic [31:0] rs2_fwd;
    logic [31:0] op_a;
    logic [31:0] op_b;
    logic [4:0]  shamt;
    logic [31:0] alu_res;
    logic        taken;

    // only a writing entry in EX/WB can forward
    assign wb_live = i_wb_valid && i_wb_pkt.we;

    assign rs1_fwd = (wb_live && (i_wb_pkt.rd == i_pkt.rs1)) ? i_wb_pkt.result : i_pkt.rs1_val;
    assign rs2_fwd = (wb_live && (i_wb_pkt.rd == i_pkt.rs2)) ? i_wb_pkt.result : i_pkt.rs2_val;

    assign op_a  = i_pkt.use_pc  ? i_pkt.pc  : rs1_fwd;
    assign op_b  = i_pkt.use_imm ? i_pkt.imm : rs2_fwd;
    assign shamt = op_b[4:0];

    always_comb begin
        case (i_pkt.alu_op)
            rv_isa_pkg::ALU_ADD:    alu_res = op_a + op_b;
            rv_isa_pkg::ALU_SUB:    alu_res = op_a - op_b;
            rv_isa_pkg::ALU_SLL:    alu_res = op_a << shamt;
            rv_isa_pkg::ALU_SLT:    alu_res = {31'd0, $signed(op_a) < $signed(op_b)};
            rv_isa_pkg::ALU_XOR:    alu_res = op_a ^ op_b;
            rv_isa_pkg::ALU_OR:     alu_res = op_a | op_b;
            rv_isa_pkg::ALU_AND:    alu_res = op_a & op_b;
            rv_isa_pkg::ALU_SRL:    alu_res = op_a >> shamt;
            rv_isa_pkg::ALU_SRA:    alu_res = $unsigned($signed(op_a) >>> shamt);
            rv_isa_pkg::ALU_PASS_B: alu_res = op_b;
            default:                alu_res = op_a + op_b;
        endcase
    end

    // branches compare the register operands, never the immediate
    always_comb begin
        case (i_pkt.br_op)
            rv_isa_pkg::BR_EQ:   taken = (rs1_fwd == rs2_fwd);
            rv_isa_pkg::BR_NE:   taken = (rs1_fwd != rs2_fwd);
            rv_isa_pkg::BR_LT:   taken = ($signed(rs1_fwd) <  $signed(rs2_fwd));
            rv_isa_pkg::BR_GE:   taken = ($signed(rs1_fwd) >= $signed(rs2_fwd));
            rv_isa_pkg::BR_JUMP: taken = 1'b1;
            default:             taken = 1'b0;
        endcase
    end

    assign o_redirect    = taken;
    assign o_redirect_pc = i_pkt.pc + i_pkt.imm;

    // jal links the return address
    assign o_pkt.pc     = i_pkt.pc;
    assign o_pkt.rd     = i_pkt.rd;
    assign o_pkt.we     = i_pkt.we;
    assign o_pkt.result = (i_pkt.br_op == rv_isa_pkg::BR_JUMP) ? i_pkt.pc + 32'd4 : alu_res;

endmodule

// ==== verilog/core.sv ====
// Top of the four-stage RV32I integer core.
// Connects fetch, decode, execute and the three stage registers; the
// EX/WB register writes the register file and forms the retire trace.

module core (
    input  logic              clk,
    input  logic              i_arst_n,
    input  logic              i_imem_ack,
    input  logic [31:0]       i_imem_data,
    output logic              o_imem_req,
    output logic [31:0]       o_imem_addr,
    output pipe_pkg::retire_t o_retire
);

    pipe_pkg::fetch_pkt_t f_pkt, if_id_pkt;
    pipe_pkg::dec_pkt_t   d_pkt, id_ex_pkt, ex_pkt;
    pipe_pkg::wb_pkt_t    e_pkt, ex_wb_pkt;
    logic                 f_valid, if_id_valid, id_ex_valid, ex_wb_valid;
    logic [4:0]           rs1, rs2;
    logic [31:0]          rs1_val, rs2_val;
    logic                 redirect;
    logic [31:0]          redirect_pc;

    fetch_unit fetch_i (
        .clk(clk), .i_arst_n(i_arst_n),
        .i_redirect(redirect), .i_redirect_pc(redirect_pc),
        .i_imem_ack(i_imem_ack), .i_imem_data(i_imem_data),
        .o_imem_req(o_imem_req), .o_imem_addr(o_imem_addr),
        .o_valid(f_valid), .o_pkt(f_pkt)
    );

    pipe_reg #(.payload_t(pipe_pkg::fetch_pkt_t)) if_id_i (
        .clk(clk), .i_arst_n(i_arst_n), .i_flush(redirect),
        .i_valid(f_valid), .i_data(f_pkt),
        .o_valid(if_id_valid), .o_data(if_id_pkt)
    );

    decode_unit decode_i (
        .i_pkt(if_id_pkt), .i_rs1_val(rs1_val), .i_rs2_val(rs2_val),
        .o_rs1(rs1), .o_rs2(rs2), .o_pkt(d_pkt)
    );

    regfile regfile_i (
        .clk(clk), .i_arst_n(i_arst_n), .i_rs1(rs1), .i_rs2(rs2),
        .i_we(ex_wb_valid && ex_wb_pkt.we), .i_rd(ex_wb_pkt.rd), .i_wdata(ex_wb_pkt.result),
        .o_rs1_val(rs1_val), .o_rs2_val(rs2_val)
    );

    pipe_reg #(.payload_t(pipe_pkg::dec_pkt_t)) id_ex_i (
        .clk(clk), .i_arst_n(i_arst_n), .i_flush(redirect),
        .i_valid(if_id_valid), .i_data(d_pkt),
        .o_valid(id_ex_valid), .o_data(id_ex_pkt)
    );

    // a bubble in ID/EX must not redirect
    always_comb begin
        ex_pkt       = id_ex_pkt;
        ex_pkt.br_op = id_ex_valid ? id_ex_pkt.br_op : rv_isa_pkg::BR_NONE;
    end

    execute_unit execute_i (
        .i_pkt(ex_pkt), .i_wb_valid(ex_wb_valid), .i_wb_pkt(ex_wb_pkt),
        .o_pkt(e_pkt), .o_redirect(redirect), .o_redirect_pc(redirect_pc)
    );

    pipe_reg #(.payload_t(pipe_pkg::wb_pkt_t)) ex_wb_i (
        .clk(clk), .i_arst_n(i_arst_n), .i_flush(1'b0),
        .i_valid(id_ex_valid), .i_data(e_pkt),
        .o_valid(ex_wb_valid), .o_data(ex_wb_pkt)
    );

    assign o_retire.valid = ex_wb_valid;
    assign o_retire.pc    = ex_wb_pkt.pc;
    assign o_retire.we    = ex_wb_pkt.we;
    assign o_retire.rd    = ex_wb_pkt.rd;
    assign o_retire.data  = ex_wb_pkt.result;

endmodule

// ==== testbench/tb_clock_gen.sv ====
// Free-running clock for the core testbench, period 10 time units.

module tb_clock_gen (
    output logic o_clk
);

    initial begin
        o_clk = 1'b0;
        forever begin
            #5 o_clk = ~o_clk;
        end
    end

endmodule

// ==== testbench/core_tb.sv ====
// Testbench for the four-stage RV32I core.
// A table holds the program and the expected retire record of each slot.
// The responder serves fetches with random ack delays, and the main loop
// checks every retire against the table in program order.

module core_tb;

    typedef struct packed {
        logic [31:0] addr;
        logic [31:0] instr;
        logic        retires;
        logic        we;
        logic [4:0]  rd;
        logic [31:0] data;
    } step_t;

    localparam int RESET_CYCLES = 16;

    logic              clk;
    logic              i_arst_n;
    logic              i_imem_ack;
    logic [31:0]       i_imem_data;
    logic              o_imem_req;
    logic [31:0]       o_imem_addr;
    pipe_pkg::retire_t o_retire;

    step_t       steps[$];
    bit          table_ready;
    logic [31:0] lcg_state;
    int          n_checked;
    int          n_value_errs;
    int          n_other_errs;

    tb_clock_gen clk_gen_i (.o_clk(clk));

    core dut_i (
        .clk(clk), .i_arst_n(i_arst_n),
        .i_imem_ack(i_imem_ack), .i_imem_data(i_imem_data),
        .o_imem_req(o_imem_req), .o_imem_addr(o_imem_addr),
        .o_retire(o_retire)
    );

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state;
    endfunction

    // past the program every word is an x0 write tagged with the folded address
    function automatic logic [31:0] imem_word(input logic [31:0] addr);
        if (addr[31:2] < steps.size()) begin
            return steps[addr[31:2]].instr;
        end
        return {addr[11:0] ^ addr[23:12] ^ {4'd0, addr[31:24]}, 20'h00013};
    endfunction

    task automatic add_step(input logic [31:0] instr, input logic retires, input logic we,
                            input logic [4:0] rd, input logic [31:0] data);
        steps.push_back({32'(steps.size() * 4), instr, retires, we, rd, data});
    endtask

    task automatic load_program();
        // x1 and x2 hold 5 and -3
        add_step(32'h0050_0093, 1'b1, 1'b1, 5'd1, 32'h0000_0005);
        add_step(32'hFFD0_0113, 1'b1, 1'b1, 5'd2, 32'hFFFF_FFFD);
        // register ops
        add_step(32'h0020_81B3, 1'b1, 1'b1, 5'd3, 32'h0000_0002);
        add_step(32'h4020_8233, 1'b1, 1'b1, 5'd4, 32'h0000_0008);
        add_step(32'h0011_22B3, 1'b1, 1'b1, 5'd5, 32'h0000_0001);
        add_step(32'h4031_5333, 1'b1, 1'b1, 5'd6, 32'hFFFF_FFFF);
        add_step(32'h0031_53B3, 1'b1, 1'b1, 5'd7, 32'h3FFF_FFFF);
        add_step(32'h0030_9433, 1'b1, 1'b1, 5'd8, 32'h0000_0014);
        add_step(32'h0020_C4B3, 1'b1, 1'b1, 5'd9, 32'hFFFF_FFF8);
        add_step(32'h0030_E533, 1'b1, 1'b1, 5'd10, 32'h0000_0007);
        add_step(32'h0020_F5B3, 1'b1, 1'b1, 5'd11, 32'h0000_0005);
        // immediate ops
        add_step(32'hFFE1_2613, 1'b1, 1'b1, 5'd12, 32'h0000_0001);
        add_step(32'h0FF0_C693, 1'b1, 1'b1, 5'd13, 32'h0000_00FA);
        add_step(32'h1000_E713, 1'b1, 1'b1, 5'd14, 32'h0000_0105);
        add_step(32'h0F01_7793, 1'b1, 1'b1, 5'd15, 32'h0000_00F0);
        add_step(32'h0040_9813, 1'b1, 1'b1, 5'd16, 32'h0000_0050);
        add_step(32'h01C1_5893, 1'b1, 1'b1, 5'd17, 32'h0000_000F);
        add_step(32'h4011_5913, 1'b1, 1'b1, 5'd18, 32'hFFFF_FFFE);
        // lui at 0x48 and auipc at 0x4c
        add_step(32'h1234_59B7, 1'b1, 1'b1, 5'd19, 32'h1234_5000);
        add_step(32'h0000_1A17, 1'b1, 1'b1, 5'd20, 32'h0000_104C);
        // write to x0 is dropped and reads back as zero
        add_step(32'h0070_8013, 1'b1, 1'b0, 5'd0, 32'h0);
        add_step(32'h0000_0A93, 1'b1, 1'b1, 5'd21, 32'h0000_0000);
        // taken beq, bne and blt each skip one slot
        add_step(32'h00B0_8463, 1'b1, 1'b0, 5'd0, 32'h0);
        add_step(32'h0010_0B13, 1'b0, 1'b0, 5'd0, 32'h0);
        add_step(32'h0020_9463, 1'b1, 1'b0, 5'd0, 32'h0);
        add_step(32'h0020_0B13, 1'b0, 1'b0, 5'd0, 32'h0);
        add_step(32'h0011_4463, 1'b1, 1'b0, 5'd0, 32'h0);
        add_step(32'h0030_0B13, 1'b0, 1'b0, 5'd0, 32'h0);
        // bge not taken, then taken
        add_step(32'h0011_5463, 1'b1, 1'b0, 5'd0, 32'h0);
        add_step(32'h0020_D463, 1'b1, 1'b0, 5'd0, 32'h0);
        add_step(32'h0040_0B13, 1'b0, 1'b0, 5'd0, 32'h0);
        // jal x23 links 0x80
        add_step(32'h0080_0BEF, 1'b1, 1'b1, 5'd23, 32'h0000_0080);
        add_step(32'h0050_0B13, 1'b0, 1'b0, 5'd0, 32'h0);
        // x22 was only written in shadow slots
        add_step(32'h016B_8C33, 1'b1, 1'b1, 5'd24, 32'h0000_0080);
        add_step(32'h004C_0CB3, 1'b1, 1'b1, 5'd25, 32'h0000_0088);
    endtask

    task automatic check_field(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        assert (got === exp) else begin
            $display("ERROR %s: got 0x%h expected 0x%h", name, got, exp);
            n_value_errs++;
        end
    endtask

    task automatic finish_run();
        $display("retires checked: %0d, value errors: %0d, other errors: %0d",
                 n_checked, n_value_errs, n_other_errs);
        if (n_value_errs + n_other_errs == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    endtask

    initial begin : imem_responder
        int delay;
        i_imem_ack  = 1'b0;
        i_imem_data = 32'd0;
        lcg_state   = 32'd34;
        wait (i_arst_n === 1'b1);
        @(negedge clk);
        // first request goes out on the first edge after reset
        assert (o_imem_req) else begin
            $display("no fetch request was raised on the first edge after reset release");
            n_other_errs++;
        end
        check_field("o_imem_addr", o_imem_addr, 32'h0000_0000);
        forever begin
            if (o_imem_req) begin
                delay = (lcg_next() >> 16) % 4;
                repeat (delay) @(negedge clk);
                i_imem_ack  = 1'b1;
                i_imem_data = imem_word(o_imem_addr);
                @(negedge clk);
                assert (!o_imem_req) else begin
                    $display("fetch still held its request after taking the acknowledge");
                    n_other_errs++;
                end
                i_imem_ack = 1'b0;
            end
            @(negedge clk);
        end
    end

    initial begin : watchdog
        int limit;
        wait (table_ready);
        limit = RESET_CYCLES + steps.size() * 40;
        repeat (limit) @(posedge clk);
        $display("timed out: the program did not finish within %0d cycles", limit);
        n_other_errs++;
        finish_run();
    end

    initial begin : main_seq
        i_arst_n     = 1'b0;
        n_checked    = 0;
        n_value_errs = 0;
        n_other_errs = 0;
        load_program();
        table_ready = 1'b1;
        repeat (RESET_CYCLES) @(negedge clk);
        i_arst_n = 1'b1;
        foreach (steps[k]) begin
            if (steps[k].retires) begin
                do begin
                    @(negedge clk);
                end while (!o_retire.valid);
                check_field("o_retire.pc", o_retire.pc, steps[k].addr);
                check_field("o_retire.we", o_retire.we, steps[k].we);
                if (steps[k].we) begin
                    check_field("o_retire.rd", o_retire.rd, steps[k].rd);
                    check_field("o_retire.data", o_retire.data, steps[k].data);
                end
                n_checked++;
            end
        end
        finish_run();
    end

endmodule

// ==== build.f ====
verilog/rv_isa_pkg.sv
verilog/pipe_pkg.sv
verilog/pipe_reg.sv
verilog/fetch_unit.sv
verilog/regfile.sv
verilog/decode_unit.sv
verilog/execute_unit.sv
verilog/core.sv
testbench/tb_clock_gen.sv
testbench/core_tb.sv
